/* flist.f */
common/fetch_pkg.sv
common/mem_pkg.sv
ibuf/ibuf_latch.sv
icache/icache_bank.sv
design/refill_arbiter.sv
design/fetch_pointer.sv
design/fetch_unit.sv
sim/tb_mem_model.sv
sim/tb_fetch.sv

/* sim/tb_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_fetch import fetch_pkg::*, mem_pkg::*; ();

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 400;
    localparam int QUIET_CYCLES    = 10;
    localparam int NUM_CONSUMES    = 24;

    localparam logic [31:0] COLD_ADDR   = 32'h0000_01a4;  // line 26, even
    localparam logic [31:0] MID_ADDR    = 32'h0000_064b;  // line 100
    localparam logic [31:0] SHARED_ADDR = 32'h0000_0c31;  // line 195, odd

    logic                   clk;
    logic                   rst_n;
    logic                   resteer_i;
    logic [LINE_ADDR_W+3:0] resteer_addr_i;
    logic                   consume_i;
    logic [3:0]             consume_len_i;
    mem_rsp_s               mem_rsp;
    mem_req_s               mem_req;
    mem_req_s               prev_req;
    ibuf_view_s             ibuf;
    bip_t                   bip;
    logic                   consume_ok;

    logic [31:0]            rnd_state = 32'h35cc_ff60;
    int                     cycle_cnt = 0;
    int                     req_cnt   = 0;
    int                     rsp_cnt   = 0;
    line_addr_t             req_log[$];
    logic [LINE_ADDR_W+3:0] pos;  // byte address under the bip

    fetch_unit #(.BANK_SETS(16)) dut_i (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .resteer_i      (resteer_i),
        .resteer_addr_i (resteer_addr_i),
        .consume_i      (consume_i),
        .consume_len_i  (consume_len_i),
        .mem_rsp_i      (mem_rsp),
        .ibuf_o         (ibuf),
        .bip_o          (bip),
        .consume_ok_o   (consume_ok),
        .mem_req_o      (mem_req)
    );

    tb_mem_model u_mem (
        .clk     (clk),
        .rst_n_i (rst_n),
        .req_i   (mem_req),
        .rsp_o   (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
        assert (act === exp) else begin
            report_failure($sformatf("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                                     $time, name, exp, act));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic line_t expected_line(input line_addr_t a);
        line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = {a[25:0], a[27:26], 2'b00, 2'(w)};
        end
        return l;
    endfunction

    function automatic logic [3:0] pair_mask(input line_addr_t l);
        logic [3:0] m;
        m = '0;
        m[l[1:0]] = 1'b1;
        m[slot_t'(l[1:0] + 2'd1)] = 1'b1;
        return m;
    endfunction

    function automatic int count_requests(input line_addr_t a);
        int n = 0;
        foreach (req_log[i]) begin
            if (req_log[i] == a) n++;
        end
        return n;
    endfunction

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= NUM_TESTS * CYCLES_PER_TEST) begin
            report_failure("timeout: test did not finish");
        end
    end

    // refill bus monitor, sampled mid cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (mem_rsp.valid) rsp_cnt++;
            if (mem_req.valid && !prev_req.valid) begin
                check_val("refills answered before new mem_req_o", req_cnt, rsp_cnt);
                req_log.push_back(mem_req.addr);
                req_cnt++;
            end
            if (mem_req.valid && prev_req.valid) begin
                check_val("mem_req_o.addr", prev_req.addr, mem_req.addr);
            end
        end
        prev_req = mem_req;
    end

    task automatic next_cycle;
        @(posedge clk);
        #5;
    endtask

    task automatic wait_valid(input logic [3:0] mask);
        while ((ibuf.valid & mask) != mask) next_cycle();
    endtask

    // wait until the refill bus has been idle for a while
    task automatic settle;
        int quiet = 0;
        while (quiet < QUIET_CYCLES) begin
            next_cycle();
            quiet = mem_req.valid ? 0 : quiet + 1;
        end
    endtask

    task automatic resteer(input logic [LINE_ADDR_W+3:0] addr);
        consume_i      = 1'b0;
        resteer_i      = 1'b1;
        resteer_addr_i = addr;
        next_cycle();
        resteer_i = 1'b0;
        pos       = addr;
    endtask

    // slot s holds the line of the window at the bip that maps to s
    task automatic check_buffer(input int stale_slot);
        line_addr_t cur;
        line_addr_t want;
        cur = pos[LINE_ADDR_W+3:4];
        check_val("bip_o", pos[5:0], bip);
        for (int s = 0; s < NUM_SLOTS; s++) begin
            want = cur + line_addr_t'((s - cur[1:0]) & 3);
            if (ibuf.valid[s] && s != stale_slot) begin
                check_val($sformatf("ibuf_o.line[%0d]", s), expected_line(want), ibuf.line[s]);
            end
        end
    endtask

    task automatic reset_test;
        check_val("ibuf_o.valid", 4'h0, ibuf.valid);
        check_val("mem_req_o.valid", 1'b0, mem_req.valid);
        consume_i     = 1'b1;  // empty buffer, must be refused
        consume_len_i = 4'd3;
        #10;
        check_val("consume_ok_o", 1'b0, consume_ok);
        next_cycle();
        consume_i = 1'b0;
        check_val("bip_o", 6'h00, bip);
    endtask

    task automatic cold_test;
        line_addr_t l;
        settle();
        req_log.delete();
        resteer(COLD_ADDR);
        l = COLD_ADDR[LINE_ADDR_W+3:4];
        wait_valid(pair_mask(l));
        check_buffer(-1);
        settle();
        check_val("requests for line L", 1, count_requests(l));
        check_val("requests for line L+1", 1, count_requests(l + 1'b1));
    endtask

    task automatic stream_test;
        int         stale;
        int         taken;
        logic [3:0] len;
        logic [3:0] old_off;
        slot_t      old_slot;
        stale = -1;
        taken = 0;
        while (taken < NUM_CONSUMES) begin
            check_buffer(stale);
            rnd_state     = xorshift32(rnd_state);
            len           = 4'(rnd_state % 15 + 1);
            consume_i     = 1'b1;
            consume_len_i = len;
            #10;
            check_val("consume_ok_o", ibuf.valid[pos[5:4]], consume_ok);
            if (consume_ok) begin
                old_off  = pos[3:0];
                old_slot = pos[5:4];
                pos      = pos + len;
                taken++;
                stale    = (pos[3:0] < old_off) ? int'(old_slot) : -1;  // one cycle late
            end else begin
                stale = -1;
            end
            next_cycle();
        end
        consume_i = 1'b0;
        next_cycle();
        wait_valid(4'hf);
        check_buffer(-1);
    endtask

    task automatic hit_test;
        settle();
        req_log.delete();
        resteer(COLD_ADDR);
        wait_valid(4'hf);
        check_buffer(-1);
        settle();
        check_val("refill requests on hit path", 0, req_log.size());
    endtask

    task automatic resteer_test;
        settle();
        consume_len_i = 4'd7;
        repeat (5) begin
            consume_i = 1'b1;
            next_cycle();
        end
        resteer(MID_ADDR);
        check_val("ibuf_o.valid", 4'h0, ibuf.valid);
        wait_valid(4'hf);
        check_buffer(-1);
    endtask

    task automatic shared_refill_test;
        line_addr_t l;
        logic       both;
        settle();
        req_log.delete();
        resteer(SHARED_ADDR);
        l = SHARED_ADDR[LINE_ADDR_W+3:4];
        wait_valid(pair_mask(l));
        both = (req_log.size() >= 2) &&
               ((req_log[0] == l && req_log[1] == l + 1'b1) ||
                (req_log[0] == l + 1'b1 && req_log[1] == l));
        assert (both) else begin
            report_failure("shared refill did not request both missing lines in turn");
        end
        check_buffer(-1);
    endtask

    initial begin
        rst_n          = 1'b0;
        resteer_i      = 1'b0;
        resteer_addr_i = '0;
        consume_i      = 1'b0;
        consume_len_i  = '0;
        repeat (16) @(posedge clk);
        #5;
        rst_n = 1'b1;
        reset_test();
        cold_test();
        stream_test();
        hit_test();
        resteer_test();
        shared_refill_test();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tb_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model import fetch_pkg::*, mem_pkg::*; #(
    parameter int RSP_DELAY = 3
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  mem_req_s req_i,
    output mem_rsp_s rsp_o
);

    mem_rsp_s   rsp_q    = '0;
    logic       busy     = 1'b0;
    int         wait_cnt = 0;
    line_addr_t addr     = '0;

    // each word holds the line address above its word index
    function automatic line_t line_pattern(input line_addr_t a);
        line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = {a[25:0], a[27:26], 2'b00, 2'(w)};
        end
        return l;
    endfunction

    always @(posedge clk) begin
        logic fire;
        fire = 1'b0;
        if (!rst_n_i) begin
            busy = 1'b0;
        end else if (busy) begin
            wait_cnt++;
            if (wait_cnt == RSP_DELAY) begin
                fire = 1'b1;
                busy = 1'b0;
            end
        end else if (req_i.valid && !rsp_q.valid) begin  // request still seen in strobe cycle
            busy     = 1'b1;
            wait_cnt = 0;
            addr     = req_i.addr;
        end
        #5;
        rsp_q.valid = fire;
        rsp_q.data  = fire ? line_pattern(addr) : '0;
    end

    assign rsp_o = rsp_q;

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit import fetch_pkg::*, mem_pkg::*; #(
    parameter int BANK_SETS = 16
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   resteer_i,
    input  logic [LINE_ADDR_W+3:0] resteer_addr_i,
    input  logic                   consume_i,
    input  logic [3:0]             consume_len_i,
    input  mem_rsp_s               mem_rsp_i,
    output ibuf_view_s             ibuf_o,
    output bip_t                   bip_o,
    output logic                   consume_ok_o,
    output mem_req_s               mem_req_o
);

    line_addr_t  fip_e;
    line_addr_t  fip_o;
    bip_t        old_bip;
    fetch_line_s even_line;
    fetch_line_s odd_line;
    logic        even_loaded;
    logic        odd_loaded;
    mem_req_s    req_even;
    mem_req_s    req_odd;
    logic        fill_even;
    logic        fill_odd;
    line_t       fill_data;

    fetch_pointer u_fetch_pointer (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .resteer_i      (resteer_i),
        .resteer_addr_i (resteer_addr_i),
        .consume_i      (consume_i),
        .consume_len_i  (consume_len_i),
        .even_loaded_i  (even_loaded),
        .odd_loaded_i   (odd_loaded),
        .slot_valid_i   (ibuf_o.valid),
        .fip_e_o        (fip_e),
        .fip_o_o        (fip_o),
        .bip_o          (bip_o),
        .old_bip_o      (old_bip),
        .consume_ok_o   (consume_ok_o)
    );

    icache_bank #(.BANK_SETS(BANK_SETS)) u_bank_even (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (resteer_i),
        .lookup_addr_i (fip_e),
        .fill_i        (fill_even),
        .fill_data_i   (fill_data),
        .line_o        (even_line),
        .req_o         (req_even)
    );

    icache_bank #(.BANK_SETS(BANK_SETS)) u_bank_odd (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (resteer_i),
        .lookup_addr_i (fip_o),
        .fill_i        (fill_odd),
        .fill_data_i   (fill_data),
        .line_o        (odd_line),
        .req_o         (req_odd)
    );

    refill_arbiter u_refill_arbiter (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_even_i  (req_even),
        .req_odd_i   (req_odd),
        .mem_rsp_i   (mem_rsp_i),
        .mem_req_o   (mem_req_o),
        .fill_even_o (fill_even),
        .fill_odd_o  (fill_odd),
        .fill_data_o (fill_data)
    );

    // resteer is the only control-flow event seen here
    ibuf_latch u_ibuf_latch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .cf_i          (resteer_i),
        .even_line_i   (even_line),
        .odd_line_i    (odd_line),
        .bip_i         (bip_o),
        .old_bip_i     (old_bip),
        .view_o        (ibuf_o),
        .even_loaded_o (even_loaded),
        .odd_loaded_o  (odd_loaded)
    );

endmodule

`default_nettype wire

/* design/fetch_pointer.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_pointer import fetch_pkg::*, mem_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   resteer_i,
    input  logic [LINE_ADDR_W+3:0] resteer_addr_i,
    input  logic                   consume_i,
    input  logic [3:0]             consume_len_i,
    input  logic                   even_loaded_i,
    input  logic                   odd_loaded_i,
    input  logic [NUM_SLOTS-1:0]   slot_valid_i,
    output line_addr_t             fip_e_o,
    output line_addr_t             fip_o_o,
    output bip_t                   bip_o,
    output bip_t                   old_bip_o,
    output logic                   consume_ok_o
);

    line_addr_t fip_e_q;
    line_addr_t fip_o_q;
    line_addr_t rs_line;
    bip_t       bip_q;
    bip_t       old_bip_q;
    logic [5:0] bip_sum;
    logic       consume_ok;

    assign rs_line = resteer_addr_i[LINE_ADDR_W+3:4];

    // bytes are taken only from a slot that holds its line
    assign consume_ok = consume_i && !resteer_i && slot_valid_i[bip_q.slot];
    assign bip_sum    = bip_q + {2'b00, consume_len_i};  // wraps mod 64

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fip_e_q   <= '0;
            fip_o_q   <= line_addr_t'(1);
            bip_q     <= '0;
            old_bip_q <= '0;
        end else if (resteer_i) begin
            if (rs_line[0]) begin
                fip_o_q <= rs_line;
                fip_e_q <= rs_line + line_addr_t'(1);
            end else begin
                fip_e_q <= rs_line;
                fip_o_q <= rs_line + line_addr_t'(1);
            end
            bip_q     <= bip_t'(resteer_addr_i[5:0]);
            old_bip_q <= bip_t'(resteer_addr_i[5:0]);  // no crossing on a jump
        end else begin
            if (even_loaded_i) fip_e_q <= fip_e_q + line_addr_t'(2);
            if (odd_loaded_i) fip_o_q <= fip_o_q + line_addr_t'(2);
            if (consume_ok) begin
                bip_q <= bip_t'(bip_sum);
            end
            // tracks bip with one cycle lag, equal when the bip holds
            old_bip_q <= bip_q;
        end
    end

    assign fip_e_o      = fip_e_q;
    assign fip_o_o      = fip_o_q;
    assign bip_o        = bip_q;
    assign old_bip_o    = old_bip_q;
    assign consume_ok_o = consume_ok;

endmodule

`default_nettype wire

/* design/refill_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module refill_arbiter import fetch_pkg::*, mem_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  mem_req_s req_even_i,
    input  mem_req_s req_odd_i,
    input  mem_rsp_s mem_rsp_i,
    output mem_req_s mem_req_o,
    output logic     fill_even_o,
    output logic     fill_odd_o,
    output line_t    fill_data_o
);

    arb_state_e state_q;
    arb_state_e state_d;
    logic       last_odd_q;  // odd bank was served last

    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (req_even_i.valid && req_odd_i.valid) begin
                    state_d = last_odd_q ? ARB_EVEN : ARB_ODD;
                end else if (req_even_i.valid) begin
                    state_d = ARB_EVEN;
                end else if (req_odd_i.valid) begin
                    state_d = ARB_ODD;
                end
            end
            ARB_EVEN, ARB_ODD: begin
                if (mem_rsp_i.valid) state_d = ARB_IDLE;
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q    <= ARB_IDLE;
            last_odd_q <= 1'b1;  // even goes first
        end else begin
            state_q <= state_d;
            if (mem_rsp_i.valid && state_q != ARB_IDLE) begin
                last_odd_q <= (state_q == ARB_ODD);
            end
        end
    end

    always_comb begin
        case (state_q)
            ARB_EVEN: mem_req_o = req_even_i;
            ARB_ODD:  mem_req_o = req_odd_i;
            default:  mem_req_o = '0;
        endcase
    end

    assign fill_even_o = (state_q == ARB_EVEN) && mem_rsp_i.valid;
    assign fill_odd_o  = (state_q == ARB_ODD) && mem_rsp_i.valid;
    assign fill_data_o = mem_rsp_i.data;

    // memory answers only a request that was forwarded
    a_rsp_granted: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_rsp_i.valid |-> (state_q != ARB_IDLE));

endmodule

`default_nettype wire

/* icache/icache_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_bank import fetch_pkg::*, mem_pkg::*; #(
    parameter int BANK_SETS = 16
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        flush_i,
    input  line_addr_t  lookup_addr_i,
    input  logic        fill_i,
    input  line_t       fill_data_i,
    output fetch_line_s line_o,
    output mem_req_s    req_o
);

    localparam int IDX_W = $clog2(BANK_SETS);
    localparam int TAG_W = LINE_ADDR_W - IDX_W - 1;  // bit 0 is the bank parity

    logic [BANK_SETS-1:0] valid_q;
    logic [TAG_W-1:0]     tag_q [BANK_SETS];
    line_t                data_q [BANK_SETS];

    logic                 req_pend_q;
    line_addr_t           req_addr_q;

    logic [IDX_W-1:0]     lookup_idx;
    logic [TAG_W-1:0]     lookup_tag;
    logic [IDX_W-1:0]     fill_idx;
    logic [TAG_W-1:0]     fill_tag;
    logic                 hit;
    logic                 start_req;

    assign lookup_idx = lookup_addr_i[IDX_W:1];
    assign lookup_tag = lookup_addr_i[LINE_ADDR_W-1:IDX_W+1];
    assign fill_idx   = req_addr_q[IDX_W:1];
    assign fill_tag   = req_addr_q[LINE_ADDR_W-1:IDX_W+1];

    assign hit = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);

    assign line_o.hit  = hit;
    assign line_o.data = data_q[lookup_idx];
    assign line_o.slot = lookup_addr_i[1:0];

    // no new miss is taken in the resteer cycle, the address is stale
    assign start_req = !req_pend_q && !hit && !flush_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q    <= '0;
            req_pend_q <= 1'b0;
        end else if (fill_i) begin
            valid_q[fill_idx] <= 1'b1;
            req_pend_q        <= 1'b0;
        end else if (start_req) begin
            req_pend_q <= 1'b1;
        end
    end

    // miss address, held constant while the request is pending
    always_ff @(posedge clk) begin
        if (start_req) begin
            req_addr_q <= lookup_addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[fill_idx]  <= fill_tag;
            data_q[fill_idx] <= fill_data_i;
        end
    end

    assign req_o.valid = req_pend_q;
    assign req_o.addr  = req_addr_q;

    // the arbiter only routes a fill to a bank that asked for one
    a_fill_pending: assert property (@(posedge clk) disable iff (!rst_n_i)
        fill_i |-> req_pend_q);

endmodule

`default_nettype wire

/* ibuf/ibuf_latch.sv */
`timescale 1ns/100ps
`default_nettype none

module ibuf_latch import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        cf_i,
    input  fetch_line_s even_line_i,
    input  fetch_line_s odd_line_i,
    input  bip_t        bip_i,
    input  bip_t        old_bip_i,
    output ibuf_view_s  view_o,
    output logic        even_loaded_o,
    output logic        odd_loaded_o
);

    logic  [NUM_SLOTS-1:0] valid_q;
    logic  [NUM_SLOTS-1:0] valid_d;
    line_t [NUM_SLOTS-1:0] line_q;
    logic  [NUM_SLOTS-1:0] ld;
    logic  [NUM_SLOTS-1:0] inval;
    ld_count_e             ld_q;
    logic                  allow_even;
    logic                  allow_odd;
    logic                  crossed;

    // how many lines the buffer can take, given the valid pattern
    function automatic ld_count_e next_count(input logic [NUM_SLOTS-1:0] v);
        logic pair_empty;
        logic even_gap;
        logic odd_gap;
        pair_empty = (~v[0] & ~v[1]) | (~v[1] & ~v[2]) |
                     (~v[2] & ~v[3]) | (~v[3] & ~v[0]);
        even_gap   = v[1] & v[3] & (~v[0] | ~v[2]);  // odd neighbours both held
        odd_gap    = v[0] & v[2] & (~v[1] | ~v[3]);
        if (pair_empty) begin
            return LD_BOTH;
        end else if (even_gap) begin
            return LD_EVEN;
        end else if (odd_gap) begin
            return LD_ODD;
        end
        return LD_NONE;
    endfunction

    assign allow_even = (ld_q == LD_EVEN) || (ld_q == LD_BOTH);
    assign allow_odd  = (ld_q == LD_ODD) || (ld_q == LD_BOTH);

    // offset wrapped, so the bip left the line of the old slot
    assign crossed = bip_i.offset < old_bip_i.offset;

    always_comb begin
        fetch_line_s src;
        logic        allow;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            src   = (s % 2 == 1) ? odd_line_i : even_line_i;
            allow = (s % 2 == 1) ? allow_odd : allow_even;
            ld[s] = !cf_i && allow && src.hit && (src.slot == slot_t'(s));
        end
    end

    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            inval[s] = cf_i || (crossed && (old_bip_i.slot == slot_t'(s)));
        end
    end

    // a load wins over the crossing invalidate of the same slot
    assign valid_d = ld | (valid_q & ~inval);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            ld_q    <= LD_BOTH;
        end else begin
            valid_q <= valid_d;
            if (cf_i) begin
                ld_q <= LD_BOTH;
            end else if ((ld | inval) != '0) begin
                ld_q <= next_count(valid_d);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (ld[s]) begin
                line_q[s] <= (s % 2 == 1) ? odd_line_i.data : even_line_i.data;
            end
        end
    end

    assign even_loaded_o = ld[0] | ld[2];
    assign odd_loaded_o  = ld[1] | ld[3];

    assign view_o.line  = line_q;
    assign view_o.valid = valid_q;

    // load count and fetch pointer together must never overwrite a live line
    a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n_i)
        (valid_q & ld & ~inval) == '0);

endmodule

`default_nettype wire

/* common/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    import fetch_pkg::*;

    localparam int LINE_ADDR_W = 28;

    typedef logic [LINE_ADDR_W-1:0] line_addr_t;

    // request level, held until the response strobe
    typedef struct packed {
        logic       valid;
        line_addr_t addr;
    } mem_req_s;

    typedef struct packed {
        logic  valid;  // one cycle strobe
        line_t data;
    } mem_rsp_s;

    typedef enum logic [1:0] {
        ARB_IDLE = 2'b00,
        ARB_EVEN = 2'b01,
        ARB_ODD  = 2'b10
    } arb_state_e;

endpackage

`default_nettype wire

/* common/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    localparam int LINE_W    = 128;
    localparam int NUM_SLOTS = 4;

    typedef logic [LINE_W-1:0] line_t;

    // slot = line address mod 4
    typedef logic [1:0] slot_t;

    typedef struct packed {
        slot_t      slot;
        logic [3:0] offset;  // byte within the line
    } bip_t;

    // bit 1 allows the even bank, bit 0 the odd bank
    typedef enum logic [1:0] {
        LD_NONE = 2'b00,
        LD_ODD  = 2'b01,
        LD_EVEN = 2'b10,
        LD_BOTH = 2'b11
    } ld_count_e;

    // lookup result of one bank in fetch1
    typedef struct packed {
        logic  hit;
        line_t data;
        slot_t slot;
    } fetch_line_s;

    typedef struct packed {
        line_t [NUM_SLOTS-1:0] line;
        logic  [NUM_SLOTS-1:0] valid;
    } ibuf_view_s;

endpackage

`default_nettype wire
